//--- list.f
source/mfifoPkg.sv
source/flopRam.sv
source/freeList.sv
source/linkedListCtrl.sv
source/popStaging.sv
source/sharedMultiFifo.sv
test/sharedMultiFifo_assertions.sv
test/sharedMultiFifoTb.sv

//--- source/flopRam.sv
// Flop-based RAM with one write and one read port
// Read data is registered one cycle after the request and is write-first on collision
`timescale 1ns/1ps

module flopRam #(
  parameter int Width = 16
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 wrValid,
  input  mfifoPkg::addrT       wrAddr,
  input  logic [Width-1:0]     wrData,
  input  logic                 rdValid,
  input  mfifoPkg::addrT       rdAddr,
  output logic [Width-1:0]     rdData
);

  // Storage array, one word per entry
  logic [Width-1:0] mem [mfifoPkg::Depth];

  // High when this cycle writes the very entry being read
  logic collide;

  assign collide = wrValid && (wrAddr == rdAddr);

  // Array write, the storage itself has no reset
  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Registered read port
  // On a collision the new word is forwarded so a link written this
  // cycle is seen by a read of the same address
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdData <= '0;
    end else if (rdValid) begin
      if (collide) begin
        rdData <= wrData;
      end else begin
        rdData <= mem[rdAddr];
      end
    end
  end

endmodule

//--- source/freeList.sv
// Free list of data RAM entries
// Circular queue of unused addresses, popped on allocation and appended on dealloc
`timescale 1ns/1ps

module freeList (
  input  logic           clk,
  input  logic           arstN,
  input  logic           allocTake,
  output mfifoPkg::addrT allocAddr,
  output logic           freeAvail,
  input  logic           deallocValid,
  input  mfifoPkg::addrT deallocAddr
);

  // Queue storage holds addresses, not data
  mfifoPkg::addrT queue [mfifoPkg::Depth];

  // Read and write indices wrap naturally because Depth is a power of two
  mfifoPkg::addrT rdIdx;
  mfifoPkg::addrT wrIdx;

  // Number of free addresses currently queued
  mfifoPkg::countT count;

  // Allocation only happens when an address is really there
  logic takeOk;

  assign takeOk    = allocTake && freeAvail;
  assign allocAddr = queue[rdIdx];

  // Availability is taken from the registered count only
  // An address returned this cycle cannot be handed out before the next one
  assign freeAvail = (count != '0);

  // Queue contents
  // At reset every entry is free, in ascending order
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < mfifoPkg::Depth; i++) begin
        queue[i] <= mfifoPkg::addrT'(i);
      end
    end else if (deallocValid) begin
      queue[wrIdx] <= deallocAddr;
    end
  end

  // Indices and occupancy
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdIdx <= '0;
      // The queue starts full, so the write index has wrapped onto the read index
      wrIdx <= '0;
      count <= mfifoPkg::countT'(mfifoPkg::Depth);
    end else begin
      if (takeOk) begin
        rdIdx <= rdIdx + mfifoPkg::addrT'(1);
      end
      if (deallocValid) begin
        wrIdx <= wrIdx + mfifoPkg::addrT'(1);
      end
      // Net change when both ends move in one cycle
      count <= count + mfifoPkg::countT'(deallocValid) - mfifoPkg::countT'(takeOk);
    end
  end

endmodule

//--- source/linkedListCtrl.sv
// Linked-list controller for the shared multi-FIFO
// Keeps head, tail and count per FIFO and drives both RAMs on push and refill
`timescale 1ns/1ps

module linkedListCtrl (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          pushAccept,
  input  mfifoPkg::fifoIdT              pushId,
  input  mfifoPkg::addrT                allocAddr,
  input  logic                          refillGrant,
  input  mfifoPkg::fifoIdT              refillId,
  output logic [mfifoPkg::NumFifos-1:0] listNonEmpty,
  output logic                          ptrWrValid,
  output mfifoPkg::addrT                ptrWrAddr,
  output mfifoPkg::addrT                ptrWrData,
  output logic                          rdValid,
  output mfifoPkg::addrT                rdAddr,
  input  mfifoPkg::addrT                ptrRdData,
  output logic                          deallocValid,
  output mfifoPkg::addrT                deallocAddr
);

  // Per-FIFO list state
  mfifoPkg::addrT  head  [mfifoPkg::NumFifos];
  mfifoPkg::addrT  tail  [mfifoPkg::NumFifos];
  mfifoPkg::countT count [mfifoPkg::NumFifos];

  // Read in flight, its data and next pointer arrive next cycle
  logic             pendValid;
  mfifoPkg::fifoIdT pendId;
  mfifoPkg::addrT   pendAddr;

  // Count of the FIFO being pushed, before this cycle's update
  logic pushToEmpty;

  assign pushToEmpty = (count[pushId] == '0);

  // A FIFO is nonempty while it has entries that no read has claimed yet
  always_comb begin
    for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
      listNonEmpty[i] = (count[i] != '0);
    end
  end

  // Link the old tail to the new entry
  // Nothing to link when the list was empty
  assign ptrWrValid = pushAccept && !pushToEmpty;
  assign ptrWrAddr  = tail[pushId];
  assign ptrWrData  = allocAddr;

  // Both RAMs are read at the head of the granted FIFO
  assign rdValid = refillGrant;
  assign rdAddr  = head[refillId];

  // Once its data has left the RAM the entry goes back to the free list
  assign deallocValid = pendValid;
  assign deallocAddr  = pendAddr;

  // Record the read that was just issued
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pendValid <= 1'b0;
      pendId    <= '0;
      pendAddr  <= '0;
    end else begin
      pendValid <= refillGrant;
      if (refillGrant) begin
        pendId   <= refillId;
        pendAddr <= head[refillId];
      end
    end
  end

  // Head, tail and count update
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
        head[i]  <= '0;
        tail[i]  <= '0;
        count[i] <= '0;
      end
    end else begin
      // Head advances to the link read along with the departing entry
      // When a push in the same cycle as that read hit a one-entry list,
      // the write-first pointer RAM already returned the new entry here
      if (pendValid) begin
        head[pendId] <= ptrRdData;
      end

      // Append on push
      // A push into a list that the last read emptied overrides the stale link
      if (pushAccept) begin
        tail[pushId] <= allocAddr;
        if (pushToEmpty) begin
          head[pushId] <= allocAddr;
        end
      end

      // Count follows the net effect of push and grant per FIFO
      for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
        count[i] <= count[i]
                    + mfifoPkg::countT'(pushAccept && (pushId == mfifoPkg::fifoIdT'(i)))
                    - mfifoPkg::countT'(refillGrant && (refillId == mfifoPkg::fifoIdT'(i)));
      end
    end
  end

endmodule

//--- source/mfifoPkg.sv
// Shared multi-FIFO package
// Sizes, vector types, the push request struct and the staging slot states
package mfifoPkg;

  // Number of logical FIFOs that share the data RAM
  localparam int NumFifos = 4;

  // Entries in the shared data RAM, and so in the pointer RAM too
  localparam int Depth = 16;

  // Width of one data word
  localparam int DataWidth = 16;

  // Address width for both RAMs
  localparam int AddrWidth = 4;

  // Width of a binary FIFO id
  localparam int FifoIdWidth = 2;

  // One data word as stored in the data RAM
  typedef logic [DataWidth-1:0] dataT;

  // An entry address, valid for the data RAM and the pointer RAM alike
  typedef logic [AddrWidth-1:0] addrT;

  // Logical FIFO id
  typedef logic [FifoIdWidth-1:0] fifoIdT;

  // Entry count from 0 up to Depth inclusive, hence one extra bit
  typedef logic [AddrWidth:0] countT;

  // Push request, the target FIFO travels with its data
  typedef struct packed {
    fifoIdT fifoId;
    dataT   data;
  } pushReqT;

  // Staging slot state
  // slotFilling means a RAM read is in flight for that FIFO
  typedef enum logic [1:0] {
    slotEmpty   = 2'd0,
    slotFilling = 2'd1,
    slotFull    = 2'd2
  } slotStateT;

endpackage

//--- source/popStaging.sv
// Pop-side staging for the shared multi-FIFO
// One slot per FIFO, round-robin refill from the single RAM read port
`timescale 1ns/1ps

module popStaging (
  input  logic                                          clk,
  input  logic                                          arstN,
  input  logic [mfifoPkg::NumFifos-1:0]                 listNonEmpty,
  output logic                                          refillGrant,
  output mfifoPkg::fifoIdT                              refillId,
  input  mfifoPkg::dataT                                rdData,
  output logic [mfifoPkg::NumFifos-1:0]                 popValid,
  input  logic [mfifoPkg::NumFifos-1:0]                 popReady,
  output mfifoPkg::dataT [mfifoPkg::NumFifos-1:0]       popData,
  output logic [mfifoPkg::NumFifos-1:0]                 popEmpty
);

  // Slot state and payload
  mfifoPkg::slotStateT state    [mfifoPkg::NumFifos];
  mfifoPkg::dataT      slotData [mfifoPkg::NumFifos];

  // Refill requests and pops of this cycle
  logic [mfifoPkg::NumFifos-1:0] refillReq;
  logic [mfifoPkg::NumFifos-1:0] popped;

  // Round-robin pointer, the first FIFO looked at next cycle
  mfifoPkg::fifoIdT rrPtr;

  // Grant seen one cycle ago, tells which slot the RAM data belongs to
  logic             fillValid;
  mfifoPkg::fifoIdT fillId;

  always_comb begin
    for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
      popValid[i] = (state[i] == mfifoPkg::slotFull);
      popData[i]  = slotData[i];
      popped[i]   = popValid[i] && popReady[i];
      // An empty slot refills, and so does a full one that is leaving now
      refillReq[i] = listNonEmpty[i] &&
                     ((state[i] == mfifoPkg::slotEmpty) || popped[i]);
      // Nothing staged, nothing in flight and nothing left in the list
      popEmpty[i] = (state[i] == mfifoPkg::slotEmpty) && !listNonEmpty[i];
    end
  end

  // Round-robin arbiter, scans upward from rrPtr and wraps
  always_comb begin : rrArbiter
    mfifoPkg::fifoIdT candId;
    refillGrant = 1'b0;
    refillId    = rrPtr;
    for (int k = 0; k < mfifoPkg::NumFifos; k++) begin
      candId = rrPtr + mfifoPkg::fifoIdT'(k);
      if (!refillGrant && refillReq[candId]) begin
        refillGrant = 1'b1;
        refillId    = candId;
      end
    end
  end

  // Arbiter pointer and the grant record
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rrPtr     <= '0;
      fillValid <= 1'b0;
      fillId    <= '0;
    end else begin
      fillValid <= refillGrant;
      if (refillGrant) begin
        // Move past the FIFO just served
        rrPtr  <= refillId + mfifoPkg::fifoIdT'(1);
        fillId <= refillId;
      end
    end
  end

  // Slot state machines
  // Grant wins over pop so a popped slot goes straight to filling
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
        state[i] <= mfifoPkg::slotEmpty;
      end
    end else begin
      for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
        if (refillGrant && (refillId == mfifoPkg::fifoIdT'(i))) begin
          state[i] <= mfifoPkg::slotFilling;
        end else if (fillValid && (fillId == mfifoPkg::fifoIdT'(i))) begin
          state[i] <= mfifoPkg::slotFull;
        end else if (popped[i]) begin
          state[i] <= mfifoPkg::slotEmpty;
        end
      end
    end
  end

  // Slot payload, loaded as the RAM read data returns
  always_ff @(posedge clk) begin
    if (fillValid) begin
      slotData[fillId] <= rdData;
    end
  end

endmodule

//--- source/sharedMultiFifo.sv
// Shared-storage multi-FIFO top level
// Four linked-list FIFOs over one 16-entry flop RAM with per-FIFO pop ports
`timescale 1ns/1ps

module sharedMultiFifo (
  input  logic                                    clk,
  input  logic                                    arstN,
  input  logic                                    pushValid,
  output logic                                    pushReady,
  input  mfifoPkg::pushReqT                       pushReq,
  output logic                                    pushFull,
  output logic [mfifoPkg::NumFifos-1:0]           popValid,
  input  logic [mfifoPkg::NumFifos-1:0]           popReady,
  output mfifoPkg::dataT [mfifoPkg::NumFifos-1:0] popData,
  output logic [mfifoPkg::NumFifos-1:0]           popEmpty
);

  // Push side
  logic           pushAccept;
  logic           freeAvail;
  mfifoPkg::addrT allocAddr;

  // Dealloc path from the controller back to the free list
  logic           deallocValid;
  mfifoPkg::addrT deallocAddr;

  // RAM control from the controller
  logic           ptrWrValid;
  mfifoPkg::addrT ptrWrAddr;
  mfifoPkg::addrT ptrWrData;
  logic           rdValid;
  mfifoPkg::addrT rdAddr;
  mfifoPkg::addrT ptrRdData;
  mfifoPkg::dataT dataRdData;

  // Refill arbitration between staging and controller
  logic                          refillGrant;
  mfifoPkg::fifoIdT              refillId;
  logic [mfifoPkg::NumFifos-1:0] listNonEmpty;

  // Push is possible exactly while a free entry exists
  assign pushReady  = freeAvail;
  assign pushFull   = !freeAvail;
  assign pushAccept = pushValid && freeAvail;

  freeList i_freeList (
    .clk, .arstN,
    .allocTake(pushAccept), .allocAddr, .freeAvail,
    .deallocValid, .deallocAddr
  );

  linkedListCtrl i_linkedListCtrl (
    .clk, .arstN,
    .pushAccept, .pushId(pushReq.fifoId), .allocAddr,
    .refillGrant, .refillId, .listNonEmpty,
    .ptrWrValid, .ptrWrAddr, .ptrWrData,
    .rdValid, .rdAddr, .ptrRdData,
    .deallocValid, .deallocAddr
  );

  // Push data lands at the allocated entry in the accept cycle
  flopRam #(.Width(mfifoPkg::DataWidth)) dataRam (
    .clk, .arstN,
    .wrValid(pushAccept), .wrAddr(allocAddr), .wrData(pushReq.data),
    .rdValid, .rdAddr, .rdData(dataRdData)
  );

  // Next-entry links, read at the same address as the data
  flopRam #(.Width(mfifoPkg::AddrWidth)) ptrRam (
    .clk, .arstN,
    .wrValid(ptrWrValid), .wrAddr(ptrWrAddr), .wrData(ptrWrData),
    .rdValid, .rdAddr, .rdData(ptrRdData)
  );

  popStaging i_popStaging (
    .clk, .arstN,
    .listNonEmpty, .refillGrant, .refillId, .rdData(dataRdData),
    .popValid, .popReady, .popData, .popEmpty
  );

endmodule

//--- test/sharedMultiFifoTb.sv
// Testbench for the shared multi-FIFO
// Runs the command file, drives push and pop-ready, and checks every pop against expected data
`timescale 1ns/1ps

module sharedMultiFifoTb;

  // Cycle limit for any single wait
  localparam int WaitLimit = 1000;
  // Expected words stored per FIFO over the whole run
  localparam int ExpDepth  = 64;

  logic                                    clk;
  logic                                    arstN;
  logic                                    pushValid;
  logic                                    pushReady;
  mfifoPkg::pushReqT                       pushReq;
  logic                                    pushFull;
  logic [mfifoPkg::NumFifos-1:0]           popValid;
  logic [mfifoPkg::NumFifos-1:0]           popReady;
  mfifoPkg::dataT [mfifoPkg::NumFifos-1:0] popData;
  logic [mfifoPkg::NumFifos-1:0]           popEmpty;

  // Expected pop values in order with write and read positions per FIFO
  mfifoPkg::dataT expMem [mfifoPkg::NumFifos][ExpDepth];
  int             expWr  [mfifoPkg::NumFifos];
  int             expRd  [mfifoPkg::NumFifos];

  // Pop-ready comes from a fixed mask or from a fresh random mask each cycle
  logic [mfifoPkg::NumFifos-1:0] readyMask;
  logic [mfifoPkg::NumFifos-1:0] nextReady;
  logic                          randomReady;
  logic [31:0]                   randWord;

  sharedMultiFifo i_sharedMultiFifo (.*);

  always #5 clk = ~clk;

  task automatic abortRun();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      abortRun();
    end
  endtask

  task automatic expectWord(input mfifoPkg::fifoIdT id, input mfifoPkg::dataT data);
    if (expWr[id] == ExpDepth) begin
      $display("Too many expected values for FIFO %0d", id);
      abortRun();
    end
    expMem[id][expWr[id]] = data;
    expWr[id]++;
  endtask

  // Holds the request until pushReady is seen high before a rising edge
  task automatic pushWord(input mfifoPkg::fifoIdT id, input mfifoPkg::dataT data);
    int waited;
    waited = 0;
    pushValid      = 1'b1;
    pushReq.fifoId = id;
    pushReq.data   = data;
    @(negedge clk);
    while (!pushReady) begin
      waited++;
      if (waited > WaitLimit) begin
        $display("Timed out waiting for pushReady with a push to FIFO %0d", id);
        abortRun();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    pushValid = 1'b0;
  endtask

  function automatic bit allConsumed();
    bit done;
    done = 1'b1;
    for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
      if (expRd[i] != expWr[i]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // Opens every pop port and waits until all expected data is out
  task automatic drainAll();
    int waited;
    waited = 0;
    readyMask   = '1;
    randomReady = 1'b0;
    @(negedge clk);
    while (!allConsumed()) begin
      waited++;
      if (waited > WaitLimit) begin
        $display("Timed out waiting for all FIFOs to drain");
        abortRun();
      end
      @(negedge clk);
    end
    // The last pop completes on this edge and leaves every FIFO idle with the RAM free
    @(posedge clk);
    #1;
    checkValue("popEmpty", popEmpty, 32'hf);
    checkValue("popValid", popValid, 32'h0);
    checkValue("pushReady", pushReady, 32'h1);
  endtask

  task automatic reportBadLine(input logic [7:0] cmd);
    $display("Malformed %c line in the test data file", cmd);
    abortRun();
  endtask

  // A mask chosen at a rising edge reaches popReady 1 ns later
  // Random masks come from this process, seeded once at time zero
  initial begin
    randWord = $urandom(32'h17ee17a9);
    forever begin
      @(posedge clk);
      randWord  = $urandom;
      nextReady = randomReady ? randWord[mfifoPkg::NumFifos-1:0] : readyMask;
      #1;
      popReady = nextReady;
    end
  end

  // A pop seen at the falling edge completes on the next rising edge
  always @(negedge clk) begin
    if (arstN) begin
      if (i_sharedMultiFifo.i_assertions.failCount != 0) begin
        $display("A concurrent assertion on the DUT failed");
        abortRun();
      end
      for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
        if (popValid[i] && popReady[i]) begin
          if (expRd[i] == expWr[i]) begin
            $display("FIFO %0d popped 0x%0h with no expected value left", i, popData[i]);
            abortRun();
          end
          checkValue($sformatf("popData[%0d]", i), popData[i], expMem[i][expRd[i]]);
          expRd[i]++;
        end
      end
    end
  end

  initial begin
    int          fd;
    int          code;
    logic [7:0]  cmd;
    logic [31:0] idVal;
    logic [31:0] dataVal;
    logic [31:0] countVal;
    logic [8*120-1:0] lineBuf;
    clk         = 1'b0;
    arstN       = 1'b0;
    pushValid   = 1'b0;
    pushReq     = '0;
    popReady    = '0;
    readyMask   = '0;
    randomReady = 1'b0;
    for (int i = 0; i < mfifoPkg::NumFifos; i++) begin
      expWr[i] = 0;
      expRd[i] = 0;
    end
    repeat (3) @(posedge clk);
    #1;
    arstN = 1'b1;
    // Out of reset nothing is staged and the whole RAM is free
    checkValue("popEmpty", popEmpty, 32'hf);
    checkValue("popValid", popValid, 32'h0);
    checkValue("pushReady", pushReady, 32'h1);
    fd = $fopen("test/sharedMultiFifo_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file");
      abortRun();
    end
    code = $fscanf(fd, " %c", cmd);
    while (code == 1) begin
      case (cmd)
        "#": code = $fgets(lineBuf, fd);
        "P", "E": begin
          if ($fscanf(fd, "%h %h", idVal, dataVal) != 2) reportBadLine(cmd);
          if (cmd == "P") begin
            pushWord(idVal[1:0], dataVal[15:0]);
          end else begin
            expectWord(idVal[1:0], dataVal[15:0]);
          end
        end
        "S", "X": begin
          if ($fscanf(fd, "%h %h %d", idVal, dataVal, countVal) != 3) reportBadLine(cmd);
          // Consecutive words starting at the base value
          for (int k = 0; k < countVal; k++) begin
            if (cmd == "S") begin
              pushWord(idVal[1:0], 16'(dataVal + k));
            end else begin
              expectWord(idVal[1:0], 16'(dataVal + k));
            end
          end
        end
        "M": begin
          if ($fscanf(fd, "%h %d", dataVal, countVal) != 2) reportBadLine(cmd);
          readyMask   = dataVal[mfifoPkg::NumFifos-1:0];
          randomReady = 1'b0;
          repeat (countVal) begin
            @(posedge clk);
            #1;
          end
        end
        "N": randomReady = 1'b1;
        "F": begin
          if ($fscanf(fd, "%d", countVal) != 1) reportBadLine(cmd);
          checkValue("pushFull", pushFull, countVal);
          checkValue("pushReady", pushReady, 32'(countVal == 0));
        end
        "D": drainAll();
        default: begin
          $display("Unknown command %c in the test data file", cmd);
          abortRun();
        end
      endcase
      code = $fscanf(fd, " %c", cmd);
    end
    $fclose(fd);
    if (!allConsumed()) begin
      $display("Expected values were left unpopped at the end of the run");
      abortRun();
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- test/sharedMultiFifo_assertions.sv
// Handshake and flag assertions for the shared multi-FIFO
// Bound into every sharedMultiFifo instance
`timescale 1ns/1ps

module sharedMultiFifo_assertions (
  input logic                                    clk,
  input logic                                    arstN,
  input logic                                    pushReady,
  input logic                                    pushFull,
  input logic [mfifoPkg::NumFifos-1:0]           popValid,
  input logic [mfifoPkg::NumFifos-1:0]           popReady,
  input mfifoPkg::dataT [mfifoPkg::NumFifos-1:0] popData,
  input logic [mfifoPkg::NumFifos-1:0]           popEmpty
);

  // Failures so far, the testbench watches this count
  int failCount = 0;

  // Full flag is just the other face of the push handshake
  pushFullInverse: assert property (@(posedge clk) disable iff (!arstN)
      pushFull == !pushReady)
    else begin
      failCount++;
      $error("pushFull is not the inverse of pushReady");
    end

  for (genvar i = 0; i < mfifoPkg::NumFifos; i++) begin : perFifo
    // A stalled pop keeps offering the same word
    popHeld: assert property (@(posedge clk) disable iff (!arstN)
        popValid[i] && !popReady[i] |=> popValid[i] && $stable(popData[i]))
      else begin
        failCount++;
        $error("FIFO %0d changed popValid or popData while stalled", i);
      end

    // An empty FIFO cannot offer data
    emptyNotValid: assert property (@(posedge clk) disable iff (!arstN)
        !(popEmpty[i] && popValid[i]))
      else begin
        failCount++;
        $error("FIFO %0d shows popEmpty and popValid together", i);
      end
  end

endmodule

bind sharedMultiFifo sharedMultiFifo_assertions i_assertions (.*);

//--- test/sharedMultiFifo_testdata.txt
# Columns: command, then fields; ids, data and masks in hex, counts and cycles in decimal
# P/E fifo data, S/X fifo base count, M mask cycles, N random masks, F pushFull, D drain
# One FIFO keeps push order
X 0 1000 4
S 0 1000 4
D
# Interleaved pushes to all four FIFOs
E 0 2000
E 1 2100
E 2 2200
E 3 2300
E 1 2101
E 0 2001
P 0 2000
P 1 2100
P 2 2200
P 3 2300
P 1 2101
P 0 2001
D
# Sixteen entries in the RAM plus one staged word fill the store
M 0 2
X 1 4100 17
S 1 4100 17
F 1
M 0 4
F 1
M 2 1
M 0 3
F 0
# Freed entries are reused while FIFO 1 drains
X 2 5200 20
X 3 5300 20
M f 0
S 2 5200 20
S 3 5300 20
D
# Random pop-ready masks
X 0 7000 12
X 1 7100 12
N
S 0 7000 12
S 1 7100 12
D
